// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_ctrl
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat all.f)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) all.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
mips_ctrl_pkg.sv
decode_if.sv
step_if.sv
instr_decoder.sv
ctrl_sequencer.sv
ctrl_word_gen.sv
mips_ctrl_top.sv
mips_ctrl_asserts.sv
tb_mips_ctrl.sv

// File: ctrl_sequencer.sv
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic  clk,
    input  logic  reset,
    decode_if.seq i_dec,
    step_if.seq   o_step
);

    mips_ctrl_pkg::ctrl_state_e  state_q;
    mips_ctrl_pkg::ctrl_state_e  state_d;
    mips_ctrl_pkg::instr_class_e cls_q;
    mips_ctrl_pkg::alu_op_e      alu_op_q;
    mips_ctrl_pkg::sh_op_e       sh_op_q;
    logic                        branch_ne_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= mips_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // instruction fields captured once per instruction
    always_ff @(posedge clk) begin
        if (state_q == mips_ctrl_pkg::DECODE) begin
            cls_q       <= i_dec.instr_class;
            alu_op_q    <= i_dec.alu_op;
            sh_op_q     <= i_dec.sh_op;
            branch_ne_q <= i_dec.branch_ne;
        end
    end

    always_comb begin
        state_d = mips_ctrl_pkg::FETCH;   // most steps end the instruction
        case (state_q)
            mips_ctrl_pkg::IDLE:        state_d = mips_ctrl_pkg::FETCH;
            mips_ctrl_pkg::FETCH:       state_d = mips_ctrl_pkg::BRANCH_CALC;
            mips_ctrl_pkg::BRANCH_CALC: state_d = mips_ctrl_pkg::DECODE;
            mips_ctrl_pkg::DECODE: begin
                case (i_dec.instr_class)
                    mips_ctrl_pkg::CLS_ALU_RR: state_d = mips_ctrl_pkg::ALU_RR;
                    mips_ctrl_pkg::CLS_SLT:    state_d = mips_ctrl_pkg::ALU_SLT;
                    mips_ctrl_pkg::CLS_SHIFT:  state_d = mips_ctrl_pkg::SHIFT_CALC;
                    mips_ctrl_pkg::CLS_JR:     state_d = mips_ctrl_pkg::JUMP_REG;
                    mips_ctrl_pkg::CLS_J:      state_d = mips_ctrl_pkg::JUMP;
                    mips_ctrl_pkg::CLS_ADDI:   state_d = mips_ctrl_pkg::ALU_IMM;
                    mips_ctrl_pkg::CLS_BRANCH: state_d = mips_ctrl_pkg::BRANCH;
                    mips_ctrl_pkg::CLS_LW,
                    mips_ctrl_pkg::CLS_SW:     state_d = mips_ctrl_pkg::ADDR_CALC;
                    default:                   state_d = mips_ctrl_pkg::FETCH;   // illegal code
                endcase
            end
            mips_ctrl_pkg::ALU_RR:     state_d = mips_ctrl_pkg::WB_ALU;
            mips_ctrl_pkg::SHIFT_CALC: state_d = mips_ctrl_pkg::WB_SHIFT;
            mips_ctrl_pkg::ALU_IMM:    state_d = mips_ctrl_pkg::WB_IMM;
            mips_ctrl_pkg::ADDR_CALC: begin
                if (cls_q == mips_ctrl_pkg::CLS_LW) begin
                    state_d = mips_ctrl_pkg::MEM_READ;
                end else begin
                    state_d = mips_ctrl_pkg::MEM_WRITE;
                end
            end
            mips_ctrl_pkg::MEM_READ:   state_d = mips_ctrl_pkg::WB_LOAD;
            default:                   state_d = mips_ctrl_pkg::FETCH;
        endcase
    end

    assign o_step.state     = state_q;
    assign o_step.cls       = cls_q;
    assign o_step.alu_op    = alu_op_q;
    assign o_step.sh_op     = sh_op_q;
    assign o_step.branch_ne = branch_ne_q;

endmodule

// File: ctrl_word_gen.sv
`timescale 1ns/1ps

module ctrl_word_gen (
    step_if.gen                         i_step,
    input  logic                        i_eq,
    output logic                        o_pc_write,
    output logic                        o_mem_read,
    output logic                        o_mem_write,
    output logic                        o_ir_write,
    output logic                        o_reg_write,
    output logic                        o_i_or_d,
    output mips_ctrl_pkg::mem_to_reg_e  o_mem_to_reg,
    output mips_ctrl_pkg::pc_src_e      o_pc_src,
    output mips_ctrl_pkg::alu_op_e      o_alu_op,
    output mips_ctrl_pkg::alu_src_a_e   o_alu_src_a,
    output mips_ctrl_pkg::alu_src_b_e   o_alu_src_b,
    output mips_ctrl_pkg::reg_dst_e     o_reg_dst,
    output mips_ctrl_pkg::sh_op_e       o_sh_op
);

    mips_ctrl_pkg::reg_dst_e wb_dst;

    // R-format results go to rd, immediate and load results to rt
    always_comb begin
        case (i_step.cls)
            mips_ctrl_pkg::CLS_ALU_RR,
            mips_ctrl_pkg::CLS_SLT,
            mips_ctrl_pkg::CLS_SHIFT: wb_dst = mips_ctrl_pkg::DST_RD;
            default:                  wb_dst = mips_ctrl_pkg::DST_RT;
        endcase
    end

    always_comb begin
        o_pc_write   = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_ir_write   = 1'b0;
        o_reg_write  = 1'b0;
        o_i_or_d     = 1'b0;
        o_mem_to_reg = mips_ctrl_pkg::WB_ALU_OUT;
        o_pc_src     = mips_ctrl_pkg::PC_ALU_RESULT;
        o_alu_op     = mips_ctrl_pkg::ALU_PASS;
        o_alu_src_a  = mips_ctrl_pkg::SRC_A_PC;
        o_alu_src_b  = mips_ctrl_pkg::SRC_B_REG;
        o_reg_dst    = mips_ctrl_pkg::DST_RT;
        o_sh_op      = mips_ctrl_pkg::SH_NONE;

        case (i_step.state)
            mips_ctrl_pkg::FETCH: begin
                o_pc_write  = 1'b1;   // pc <= pc + 4
                o_mem_read  = 1'b1;
                o_ir_write  = 1'b1;
                o_alu_op    = mips_ctrl_pkg::ALU_ADD;
                o_alu_src_b = mips_ctrl_pkg::SRC_B_FOUR;
            end
            mips_ctrl_pkg::BRANCH_CALC: begin
                o_alu_op    = mips_ctrl_pkg::ALU_ADD;   // speculative branch target
                o_alu_src_b = mips_ctrl_pkg::SRC_B_IMM_SHIFT;
            end
            mips_ctrl_pkg::ALU_RR: begin
                o_alu_op    = i_step.alu_op;
                o_alu_src_a = mips_ctrl_pkg::SRC_A_REG;
            end
            mips_ctrl_pkg::ALU_SLT: begin
                o_reg_write  = 1'b1;
                o_alu_op     = mips_ctrl_pkg::ALU_SUB;
                o_alu_src_a  = mips_ctrl_pkg::SRC_A_REG;
                o_mem_to_reg = mips_ctrl_pkg::WB_LT_FLAG;
                o_reg_dst    = wb_dst;
            end
            mips_ctrl_pkg::SHIFT_CALC: o_sh_op = i_step.sh_op;
            mips_ctrl_pkg::WB_ALU, mips_ctrl_pkg::WB_IMM: begin
                o_reg_write = 1'b1;
                o_reg_dst   = wb_dst;
            end
            mips_ctrl_pkg::WB_SHIFT: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = mips_ctrl_pkg::WB_SHIFT_OUT;
                o_reg_dst    = wb_dst;
            end
            mips_ctrl_pkg::JUMP_REG: begin
                o_pc_write = 1'b1;
                o_pc_src   = mips_ctrl_pkg::PC_REG_A;
            end
            mips_ctrl_pkg::JUMP: begin
                o_pc_write = 1'b1;
                o_pc_src   = mips_ctrl_pkg::PC_JUMP_TARGET;
            end
            mips_ctrl_pkg::ALU_IMM, mips_ctrl_pkg::ADDR_CALC: begin
                o_alu_op    = mips_ctrl_pkg::ALU_ADD;
                o_alu_src_a = mips_ctrl_pkg::SRC_A_REG;
                o_alu_src_b = mips_ctrl_pkg::SRC_B_IMM;
            end
            mips_ctrl_pkg::BRANCH: begin
                o_pc_write  = i_eq ^ i_step.branch_ne;   // taken branch only
                o_alu_op    = mips_ctrl_pkg::ALU_SUB;
                o_alu_src_a = mips_ctrl_pkg::SRC_A_REG;
                o_pc_src    = mips_ctrl_pkg::PC_ALU_OUT;
            end
            mips_ctrl_pkg::MEM_READ: begin
                o_mem_read = 1'b1;
                o_i_or_d   = 1'b1;   // data address
            end
            mips_ctrl_pkg::WB_LOAD: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = mips_ctrl_pkg::WB_MEM_DATA;
                o_reg_dst    = wb_dst;
            end
            mips_ctrl_pkg::MEM_WRITE: begin
                o_mem_write = 1'b1;
                o_i_or_d    = 1'b1;
            end
            default: ;   // idle and decode drive nothing
        endcase
    end

endmodule

// File: decode_if.sv
`timescale 1ns/1ps

interface decode_if;

    mips_ctrl_pkg::instr_class_e instr_class;
    mips_ctrl_pkg::alu_op_e      alu_op;
    mips_ctrl_pkg::sh_op_e       sh_op;
    logic                        branch_ne;   // bne rather than beq

    modport dec (
        output instr_class, alu_op, sh_op, branch_ne
    );

    modport seq (
        input instr_class, alu_op, sh_op, branch_ne
    );

endinterface

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic [mips_ctrl_pkg::OPCODE_W-1:0] i_opcode,
    input  logic [mips_ctrl_pkg::FUNCT_W-1:0]  i_funct,
    decode_if.dec                              o_dec
);

    always_comb begin
        o_dec.instr_class = mips_ctrl_pkg::CLS_ILLEGAL;
        o_dec.alu_op      = mips_ctrl_pkg::ALU_PASS;
        o_dec.sh_op       = mips_ctrl_pkg::SH_NONE;
        o_dec.branch_ne   = 1'b0;

        case (i_opcode)
            mips_ctrl_pkg::OP_RTYPE: begin
                case (i_funct)
                    mips_ctrl_pkg::FN_ADD: begin
                        o_dec.instr_class = mips_ctrl_pkg::CLS_ALU_RR;
                        o_dec.alu_op      = mips_ctrl_pkg::ALU_ADD;
                    end
                    mips_ctrl_pkg::FN_SUB: begin
                        o_dec.instr_class = mips_ctrl_pkg::CLS_ALU_RR;
                        o_dec.alu_op      = mips_ctrl_pkg::ALU_SUB;
                    end
                    mips_ctrl_pkg::FN_AND: begin
                        o_dec.instr_class = mips_ctrl_pkg::CLS_ALU_RR;
                        o_dec.alu_op      = mips_ctrl_pkg::ALU_AND;
                    end
                    mips_ctrl_pkg::FN_SLT: begin
                        o_dec.instr_class = mips_ctrl_pkg::CLS_SLT;
                        o_dec.alu_op      = mips_ctrl_pkg::ALU_SUB;   // compare by subtract
                    end
                    mips_ctrl_pkg::FN_SLL: begin
                        o_dec.instr_class = mips_ctrl_pkg::CLS_SHIFT;
                        o_dec.sh_op       = mips_ctrl_pkg::SH_SLL;
                    end
                    mips_ctrl_pkg::FN_SRA: begin
                        o_dec.instr_class = mips_ctrl_pkg::CLS_SHIFT;
                        o_dec.sh_op       = mips_ctrl_pkg::SH_SRA;
                    end
                    mips_ctrl_pkg::FN_JR: o_dec.instr_class = mips_ctrl_pkg::CLS_JR;
                    default: o_dec.instr_class = mips_ctrl_pkg::CLS_ILLEGAL;
                endcase
            end
            mips_ctrl_pkg::OP_J: o_dec.instr_class = mips_ctrl_pkg::CLS_J;
            mips_ctrl_pkg::OP_ADDI: begin
                o_dec.instr_class = mips_ctrl_pkg::CLS_ADDI;
                o_dec.alu_op      = mips_ctrl_pkg::ALU_ADD;
            end
            mips_ctrl_pkg::OP_BEQ, mips_ctrl_pkg::OP_BNE: begin
                o_dec.instr_class = mips_ctrl_pkg::CLS_BRANCH;
                o_dec.alu_op      = mips_ctrl_pkg::ALU_SUB;
                o_dec.branch_ne   = (i_opcode == mips_ctrl_pkg::OP_BNE);
            end
            mips_ctrl_pkg::OP_LW: begin
                o_dec.instr_class = mips_ctrl_pkg::CLS_LW;
                o_dec.alu_op      = mips_ctrl_pkg::ALU_ADD;   // base plus offset
            end
            mips_ctrl_pkg::OP_SW: begin
                o_dec.instr_class = mips_ctrl_pkg::CLS_SW;
                o_dec.alu_op      = mips_ctrl_pkg::ALU_ADD;
            end
            default: o_dec.instr_class = mips_ctrl_pkg::CLS_ILLEGAL;
        endcase
    end

endmodule

// File: mips_ctrl_asserts.sv
`timescale 1ns/1ps

module mips_ctrl_asserts (
    input logic clk,
    input logic reset,
    input logic i_pc_write,
    input logic i_mem_read,
    input logic i_mem_write,
    input logic i_ir_write,
    input logic i_reg_write
);

    a_mem_excl: assert property (@(posedge clk) disable iff (reset)
        !(i_mem_read && i_mem_write))
        else $error("memory read and write strobes high together");

    // instruction load only during fetch
    a_ir_fetch: assert property (@(posedge clk) disable iff (reset)
        i_ir_write |-> (i_pc_write && i_mem_read))
        else $error("instruction register written outside a fetch");

    a_store_wb: assert property (@(posedge clk) disable iff (reset)
        !(i_reg_write && i_mem_write))
        else $error("register write during a memory store");

endmodule

bind mips_ctrl_top mips_ctrl_asserts i_mips_ctrl_asserts (
    .clk         (clk),
    .reset       (reset),
    .i_pc_write  (o_pc_write),
    .i_mem_read  (o_mem_read),
    .i_mem_write (o_mem_write),
    .i_ir_write  (o_ir_write),
    .i_reg_write (o_reg_write)
);

// File: mips_ctrl_pkg.sv
package mips_ctrl_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;

    // primary opcodes
    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
    localparam logic [OPCODE_W-1:0] OP_J     = 6'b000010;
    localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'b000100;
    localparam logic [OPCODE_W-1:0] OP_BNE   = 6'b000101;
    localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'b001000;
    localparam logic [OPCODE_W-1:0] OP_LW    = 6'b100011;
    localparam logic [OPCODE_W-1:0] OP_SW    = 6'b101011;

    // R-type function field
    localparam logic [FUNCT_W-1:0] FN_SLL = 6'b000000;
    localparam logic [FUNCT_W-1:0] FN_SRA = 6'b000011;
    localparam logic [FUNCT_W-1:0] FN_JR  = 6'b001000;
    localparam logic [FUNCT_W-1:0] FN_ADD = 6'b100000;
    localparam logic [FUNCT_W-1:0] FN_SUB = 6'b100010;
    localparam logic [FUNCT_W-1:0] FN_AND = 6'b100100;
    localparam logic [FUNCT_W-1:0] FN_SLT = 6'b101010;

    typedef enum logic [3:0] {
        CLS_ILLEGAL,
        CLS_ALU_RR,
        CLS_SLT,
        CLS_SHIFT,
        CLS_JR,
        CLS_J,
        CLS_ADDI,
        CLS_BRANCH,
        CLS_LW,
        CLS_SW
    } instr_class_e;

    typedef enum logic [4:0] {
        IDLE,
        FETCH,
        BRANCH_CALC,
        DECODE,
        ALU_RR,
        WB_ALU,
        ALU_SLT,
        SHIFT_CALC,
        WB_SHIFT,
        JUMP_REG,
        JUMP,
        ALU_IMM,
        WB_IMM,
        BRANCH,
        ADDR_CALC,
        MEM_READ,
        WB_LOAD,
        MEM_WRITE
    } ctrl_state_e;

    typedef enum logic [2:0] {ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND} alu_op_e;

    typedef enum logic [2:0] {SH_NONE = 3'd0, SH_SLL = 3'd2, SH_SRA = 3'd4} sh_op_e;

    typedef enum logic [1:0] {SRC_A_PC, SRC_A_REG} alu_src_a_e;

    typedef enum logic [1:0] {SRC_B_REG, SRC_B_FOUR, SRC_B_IMM, SRC_B_IMM_SHIFT} alu_src_b_e;

    typedef enum logic [1:0] {PC_ALU_RESULT, PC_ALU_OUT, PC_JUMP_TARGET, PC_REG_A} pc_src_e;

    typedef enum logic [2:0] {WB_ALU_OUT, WB_MEM_DATA, WB_SHIFT_OUT, WB_LT_FLAG} mem_to_reg_e;

    typedef enum logic [1:0] {DST_RT, DST_RD} reg_dst_e;

endpackage

// File: mips_ctrl_top.sv
`timescale 1ns/1ps

module mips_ctrl_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [mips_ctrl_pkg::OPCODE_W-1:0]   i_opcode,
    input  logic [mips_ctrl_pkg::FUNCT_W-1:0]    i_funct,
    input  logic                                 i_eq,
    output logic                                 o_pc_write,
    output logic                                 o_mem_read,
    output logic                                 o_mem_write,
    output logic                                 o_ir_write,
    output logic                                 o_reg_write,
    output logic                                 o_i_or_d,
    output mips_ctrl_pkg::mem_to_reg_e           o_mem_to_reg,
    output mips_ctrl_pkg::pc_src_e               o_pc_src,
    output mips_ctrl_pkg::alu_op_e               o_alu_op,
    output mips_ctrl_pkg::alu_src_a_e            o_alu_src_a,
    output mips_ctrl_pkg::alu_src_b_e            o_alu_src_b,
    output mips_ctrl_pkg::reg_dst_e              o_reg_dst,
    output mips_ctrl_pkg::sh_op_e                o_sh_op
);

    decode_if u_dec_if ();
    step_if   u_step_if ();

    instr_decoder u_instr_decoder (
        .i_opcode (i_opcode),
        .i_funct  (i_funct),
        .o_dec    (u_dec_if.dec)
    );

    ctrl_sequencer u_ctrl_sequencer (
        .clk    (clk),
        .reset  (reset),
        .i_dec  (u_dec_if.seq),
        .o_step (u_step_if.seq)
    );

    ctrl_word_gen u_ctrl_word_gen (
        .i_step       (u_step_if.gen),
        .i_eq         (i_eq),
        .o_pc_write   (o_pc_write),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_ir_write   (o_ir_write),
        .o_reg_write  (o_reg_write),
        .o_i_or_d     (o_i_or_d),
        .o_mem_to_reg (o_mem_to_reg),
        .o_pc_src     (o_pc_src),
        .o_alu_op     (o_alu_op),
        .o_alu_src_a  (o_alu_src_a),
        .o_alu_src_b  (o_alu_src_b),
        .o_reg_dst    (o_reg_dst),
        .o_sh_op      (o_sh_op)
    );

endmodule

// File: step_if.sv
`timescale 1ns/1ps

interface step_if;

    mips_ctrl_pkg::ctrl_state_e  state;
    // fields held from decode until the next fetch
    mips_ctrl_pkg::instr_class_e cls;
    mips_ctrl_pkg::alu_op_e      alu_op;
    mips_ctrl_pkg::sh_op_e       sh_op;
    logic                        branch_ne;

    modport seq (
        output state, cls, alu_op, sh_op, branch_ne
    );

    modport gen (
        input state, cls, alu_op, sh_op, branch_ne
    );

endinterface

// File: tb_mips_ctrl.sv
`timescale 1ns/1ps

module tb_mips_ctrl;

    typedef struct packed {
        logic       pc_write;
        logic       mem_read;
        logic       mem_write;
        logic       ir_write;
        logic       reg_write;
        logic       i_or_d;
        logic [2:0] mem_to_reg;
        logic [1:0] pc_src;
        logic [2:0] alu_op;
        logic [1:0] alu_src_a;
        logic [1:0] alu_src_b;
        logic [1:0] reg_dst;
        logic [2:0] sh_op;
    } ctrl_word_t;

    logic                              clk = 1'b0;
    logic                              reset;
    logic [mips_ctrl_pkg::OPCODE_W-1:0] i_opcode;
    logic [mips_ctrl_pkg::FUNCT_W-1:0]  i_funct;
    logic                              i_eq;
    logic                              o_pc_write;
    logic                              o_mem_read;
    logic                              o_mem_write;
    logic                              o_ir_write;
    logic                              o_reg_write;
    logic                              o_i_or_d;
    mips_ctrl_pkg::mem_to_reg_e        o_mem_to_reg;
    mips_ctrl_pkg::pc_src_e            o_pc_src;
    mips_ctrl_pkg::alu_op_e            o_alu_op;
    mips_ctrl_pkg::alu_src_a_e         o_alu_src_a;
    mips_ctrl_pkg::alu_src_b_e         o_alu_src_b;
    mips_ctrl_pkg::reg_dst_e           o_reg_dst;
    mips_ctrl_pkg::sh_op_e             o_sh_op;

    // add sub and slt sll sra jr j beq bne addi lw sw
    logic [5:0] op_tab [13] = '{6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00,
                                6'h02, 6'h04, 6'h05, 6'h08, 6'h23, 6'h2b};
    logic [5:0] fn_tab [13] = '{6'h20, 6'h22, 6'h24, 6'h2a, 6'h00, 6'h03, 6'h08,
                                6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00};

    bit         rst_seen = 1'b0;
    bit         started = 1'b0;
    int         idle_cnt = 0;
    int         step = 0;
    int         issued = 0;
    int         done_cnt = 0;
    logic [5:0] ref_op = '0;
    logic [5:0] ref_fn = '0;
    ctrl_word_t exp_w;

    mips_ctrl_top i_mips_ctrl_top (.*);

    always #4 clk = ~clk;

    // state expected at each step of an instruction
    function automatic mips_ctrl_pkg::ctrl_state_e expected_state(
        input logic [5:0] op, input logic [5:0] fn, input int idx);
        mips_ctrl_pkg::ctrl_state_e tail [3];
        tail[0] = mips_ctrl_pkg::FETCH;
        tail[1] = mips_ctrl_pkg::FETCH;
        tail[2] = mips_ctrl_pkg::FETCH;
        if (op == 6'h00 && (fn == 6'h20 || fn == 6'h22 || fn == 6'h24)) begin
            tail[0] = mips_ctrl_pkg::ALU_RR;
            tail[1] = mips_ctrl_pkg::WB_ALU;
        end else if (op == 6'h00 && fn == 6'h2a) begin
            tail[0] = mips_ctrl_pkg::ALU_SLT;
        end else if (op == 6'h00 && (fn == 6'h00 || fn == 6'h03)) begin
            tail[0] = mips_ctrl_pkg::SHIFT_CALC;
            tail[1] = mips_ctrl_pkg::WB_SHIFT;
        end else if (op == 6'h00 && fn == 6'h08) begin
            tail[0] = mips_ctrl_pkg::JUMP_REG;
        end else if (op == 6'h02) begin
            tail[0] = mips_ctrl_pkg::JUMP;
        end else if (op == 6'h08) begin
            tail[0] = mips_ctrl_pkg::ALU_IMM;
            tail[1] = mips_ctrl_pkg::WB_IMM;
        end else if (op == 6'h04 || op == 6'h05) begin
            tail[0] = mips_ctrl_pkg::BRANCH;
        end else if (op == 6'h23 || op == 6'h2b) begin
            tail[0] = mips_ctrl_pkg::ADDR_CALC;
            tail[1] = (op == 6'h23) ? mips_ctrl_pkg::MEM_READ : mips_ctrl_pkg::MEM_WRITE;
            tail[2] = (op == 6'h23) ? mips_ctrl_pkg::WB_LOAD : mips_ctrl_pkg::FETCH;
        end
        case (idx)
            0:       return mips_ctrl_pkg::FETCH;
            1:       return mips_ctrl_pkg::BRANCH_CALC;
            2:       return mips_ctrl_pkg::DECODE;
            3, 4, 5: return tail[idx-3];
            default: return mips_ctrl_pkg::FETCH;
        endcase
    endfunction

    function automatic ctrl_word_t expected_word(
        input logic [5:0] op, input logic [5:0] fn, input int idx, input logic eq);
        ctrl_word_t w;
        w = '0;
        case (expected_state(op, fn, idx))
            mips_ctrl_pkg::FETCH: begin
                w.pc_write  = 1'b1;
                w.mem_read  = 1'b1;
                w.ir_write  = 1'b1;
                w.alu_op    = mips_ctrl_pkg::ALU_ADD;
                w.alu_src_b = mips_ctrl_pkg::SRC_B_FOUR;
            end
            mips_ctrl_pkg::BRANCH_CALC: begin
                w.alu_op    = mips_ctrl_pkg::ALU_ADD;
                w.alu_src_b = mips_ctrl_pkg::SRC_B_IMM_SHIFT;
            end
            mips_ctrl_pkg::ALU_RR: begin
                w.alu_op    = (fn == 6'h22) ? mips_ctrl_pkg::ALU_SUB :
                              (fn == 6'h24) ? mips_ctrl_pkg::ALU_AND : mips_ctrl_pkg::ALU_ADD;
                w.alu_src_a = mips_ctrl_pkg::SRC_A_REG;
            end
            mips_ctrl_pkg::ALU_SLT: begin
                w.reg_write  = 1'b1;
                w.alu_op     = mips_ctrl_pkg::ALU_SUB;
                w.alu_src_a  = mips_ctrl_pkg::SRC_A_REG;
                w.mem_to_reg = mips_ctrl_pkg::WB_LT_FLAG;
                w.reg_dst    = mips_ctrl_pkg::DST_RD;
            end
            mips_ctrl_pkg::SHIFT_CALC: begin
                w.sh_op = (fn == 6'h03) ? mips_ctrl_pkg::SH_SRA : mips_ctrl_pkg::SH_SLL;
            end
            mips_ctrl_pkg::WB_ALU, mips_ctrl_pkg::WB_SHIFT: begin
                w.reg_write  = 1'b1;
                w.reg_dst    = mips_ctrl_pkg::DST_RD;
                w.mem_to_reg = (op == 6'h00 && (fn == 6'h00 || fn == 6'h03)) ?
                               mips_ctrl_pkg::WB_SHIFT_OUT : mips_ctrl_pkg::WB_ALU_OUT;
            end
            mips_ctrl_pkg::JUMP_REG, mips_ctrl_pkg::JUMP: begin
                w.pc_write = 1'b1;
                w.pc_src   = (op == 6'h02) ? mips_ctrl_pkg::PC_JUMP_TARGET : mips_ctrl_pkg::PC_REG_A;
            end
            mips_ctrl_pkg::ALU_IMM, mips_ctrl_pkg::ADDR_CALC: begin
                w.alu_op    = mips_ctrl_pkg::ALU_ADD;
                w.alu_src_a = mips_ctrl_pkg::SRC_A_REG;
                w.alu_src_b = mips_ctrl_pkg::SRC_B_IMM;
            end
            mips_ctrl_pkg::WB_IMM: w.reg_write = 1'b1;
            mips_ctrl_pkg::BRANCH: begin
                w.pc_write  = eq ^ (op == 6'h05);   // bne inverts the sense
                w.alu_op    = mips_ctrl_pkg::ALU_SUB;
                w.alu_src_a = mips_ctrl_pkg::SRC_A_REG;
                w.pc_src    = mips_ctrl_pkg::PC_ALU_OUT;
            end
            mips_ctrl_pkg::MEM_READ, mips_ctrl_pkg::MEM_WRITE: begin
                w.mem_read  = (op == 6'h23);
                w.mem_write = (op == 6'h2b);
                w.i_or_d    = 1'b1;
            end
            mips_ctrl_pkg::WB_LOAD: begin
                w.reg_write  = 1'b1;
                w.mem_to_reg = mips_ctrl_pkg::WB_MEM_DATA;
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic check_field(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %0h actual %0h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("ERROR %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_word(input ctrl_word_t e);
        check_field("o_pc_write", 8'(e.pc_write), 8'(o_pc_write));
        check_field("o_mem_read", 8'(e.mem_read), 8'(o_mem_read));
        check_field("o_mem_write", 8'(e.mem_write), 8'(o_mem_write));
        check_field("o_ir_write", 8'(e.ir_write), 8'(o_ir_write));
        check_field("o_reg_write", 8'(e.reg_write), 8'(o_reg_write));
        check_field("o_i_or_d", 8'(e.i_or_d), 8'(o_i_or_d));
        check_field("o_mem_to_reg", 8'(e.mem_to_reg), 8'(o_mem_to_reg));
        check_field("o_pc_src", 8'(e.pc_src), 8'(o_pc_src));
        check_field("o_alu_op", 8'(e.alu_op), 8'(o_alu_op));
        check_field("o_alu_src_a", 8'(e.alu_src_a), 8'(o_alu_src_a));
        check_field("o_alu_src_b", 8'(e.alu_src_b), 8'(o_alu_src_b));
        check_field("o_reg_dst", 8'(e.reg_dst), 8'(o_reg_dst));
        check_field("o_sh_op", 8'(e.sh_op), 8'(o_sh_op));
    endtask

    // outputs of the cycle that ends at this edge
    always @(posedge clk) begin
        if (rst_seen) begin
            if (!started && o_ir_write) begin
                started = 1'b1;
                assert (idle_cnt == 1)
                    else stop_with_error("idle state did not last one cycle after reset");
            end
            if (started) begin
                if (step == 2) begin
                    ref_op = i_opcode;   // decode edge
                    ref_fn = i_funct;
                end
                exp_w = expected_word(ref_op, ref_fn, step, i_eq);
            end else begin
                exp_w = '0;
                if (!reset) idle_cnt++;
            end
            compare_word(exp_w);
            if (started) begin
                step++;
                if (expected_state(ref_op, ref_fn, step) == mips_ctrl_pkg::FETCH) begin
                    step = 0;
                    done_cnt++;
                end
            end
        end
        if (reset) rst_seen = 1'b1;
    end

    task automatic wait_for_fetch();
        int cycles;
        cycles = 0;
        while (!o_ir_write) begin
            @(negedge clk);
            cycles++;
            if (cycles > 10) stop_with_error("no instruction fetch within 10 cycles");
        end
    endtask

    task automatic run_instr(input logic [5:0] op, input logic [5:0] fn, input logic eq,
                             input logic scramble);
        wait_for_fetch();
        i_opcode = op;
        i_funct  = fn;
        i_eq     = eq;
        issued++;
        @(negedge clk);
        if (scramble) begin
            repeat (2) @(negedge clk);   // now past decode
            if (!o_ir_write) begin
                i_opcode = 6'($urandom);
                i_funct  = 6'($urandom);
            end
        end
    endtask

    initial begin
        int idx;
        void'($urandom(53));
        reset    = 1'b1;
        i_opcode = '0;
        i_funct  = '0;
        i_eq     = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 13; i++) run_instr(op_tab[i], fn_tab[i], 1'b0, i >= 10);
        run_instr(6'h04, 6'h00, 1'b1, 1'b0);
        run_instr(6'h05, 6'h00, 1'b1, 1'b0);
        run_instr(6'h3f, 6'h00, 1'b0, 1'b0);   // unknown opcodes
        run_instr(6'h0f, 6'h20, 1'b1, 1'b0);
        run_instr(6'h00, 6'h1a, 1'b0, 1'b0);   // unknown functions
        run_instr(6'h00, 6'h10, 1'b1, 1'b0);
        for (int n = 0; n < 200; n++) begin
            idx = int'($urandom % 15);
            if (idx < 13) run_instr(op_tab[idx], fn_tab[idx], 1'($urandom), 1'($urandom));
            else if (idx == 13) run_instr(6'($urandom), 6'($urandom), 1'($urandom), 1'b0);
            else run_instr(6'h00, 6'($urandom), 1'($urandom), 1'b0);
        end
        wait_for_fetch();
        if (done_cnt == issued) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("ERROR checker saw %0d instructions, %0d were issued", done_cnt, issued);
            $display("SOME TESTS FAILED");
            $fatal(1, "instruction count mismatch");
        end
    end

endmodule
